// File: design/mem_seq_pkg.sv
package mem_seq_pkg;

  // Memory port widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // Words per burst, per display mode
  localparam int BURST_TXT = 8;
  localparam int BURST_GFX = 16;

  // Words per display row
  localparam int ROW_PITCH = 80;

  // CRT data FIFO size
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = 5;

  // Burst FSM states
  localparam logic [1:0] FETCH_IDLE  = 2'b00;
  localparam logic [1:0] FETCH_WAIT  = 2'b01;
  localparam logic [1:0] FETCH_WRITE = 2'b10;
  localparam logic [1:0] FETCH_DONE  = 2'b11;

  // One display word seen either as text or as four pixels
  // pix[0] sits in the low nibble and goes out first
  typedef union packed {
    struct packed {
      logic [7:0] attr;
      logic [7:0] char_code;
    } txt;
    struct packed {
      logic [3:0][3:0] pix;
    } gfx;
  } mem_word_u;

endpackage

// File: design/crt_fetch_ctrl.sv
`timescale 1ns/100ps

module crt_fetch_ctrl
  import mem_seq_pkg::*;
(
  input  logic t_mem_clk,
  input  logic h_reset_n,
  input  logic fetch_req,
  input  logic t_data_ready_n,
  input  logic sync_c_crt_line_end,
  input  logic text_mode,
  output logic crt_busy,
  output logic crt_ff_write,
  output logic data_complete
);

  logic [1:0] state;
  logic [1:0] next_state;
  logic [3:0] dardy_cnt;
  logic       cnt_msb;
  logic       burst_end;
  logic       dardy_cnt_inc;

  // Bit 3 ignored in text mode so the burst stops at 8
  assign cnt_msb   = text_mode ? 1'b0 : dardy_cnt[3];
  assign burst_end = ({cnt_msb, dardy_cnt[2:0]} == 4'd0);

  // Only strobes seen while waiting belong to the burst
  assign dardy_cnt_inc = (state == FETCH_WAIT) && !t_data_ready_n;

  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      state <= FETCH_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      FETCH_IDLE: begin
        if (fetch_req) begin
          next_state = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (sync_c_crt_line_end) begin
          next_state = FETCH_DONE;
        end else if (!t_data_ready_n) begin
          next_state = FETCH_WRITE;
        end
      end
      FETCH_WRITE: begin
        // Counter already holds this word, so zero means full burst
        if (burst_end || sync_c_crt_line_end) begin
          next_state = FETCH_DONE;
        end else begin
          next_state = FETCH_WAIT;
        end
      end
      FETCH_DONE: begin
        next_state = FETCH_IDLE;
      end
      default: begin
        next_state = FETCH_IDLE;
      end
    endcase
  end

  // Ready counter, wraps at 16 in graphics mode
  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      dardy_cnt <= 4'd0;
    end else if (sync_c_crt_line_end) begin
      dardy_cnt <= 4'd0;
    end else if (data_complete && text_mode) begin
      dardy_cnt <= 4'd0;
    end else if (dardy_cnt_inc) begin
      dardy_cnt <= dardy_cnt + 4'd1;
    end
  end

  assign crt_busy      = (state != FETCH_IDLE);
  assign crt_ff_write  = (state == FETCH_WRITE);
  assign data_complete = (state == FETCH_DONE);

endmodule

// File: design/crt_addr_gen.sv
`timescale 1ns/100ps

module crt_addr_gen
  import mem_seq_pkg::*;
(
  input  logic              t_mem_clk,
  input  logic              h_reset_n,
  input  logic              crt_ff_write,
  input  logic              sync_c_crt_line_end,
  input  logic              frame_start,
  output logic [ADDR_W-1:0] crt_addr
);

  logic [ADDR_W-1:0] row_start;
  logic [ADDR_W-1:0] word_offset;

  // Start of the current display row
  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      row_start <= '0;
    end else if (frame_start) begin
      row_start <= '0;
    end else if (sync_c_crt_line_end) begin
      row_start <= row_start + ADDR_W'(ROW_PITCH);
    end
  end

  // Words fetched so far in this row
  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      word_offset <= '0;
    end else if (frame_start || sync_c_crt_line_end) begin
      word_offset <= '0;
    end else if (crt_ff_write) begin
      word_offset <= word_offset + 1'b1;
    end
  end

  assign crt_addr = row_start + word_offset;

endmodule

// File: design/crt_data_fifo.sv
`timescale 1ns/100ps

module crt_data_fifo
  import mem_seq_pkg::*;
(
  input  logic              t_mem_clk,
  input  logic              h_reset_n,
  input  logic              text_mode,
  input  logic              crt_ff_write,
  input  logic [DATA_W-1:0] wdata,
  input  logic              crt_rd,
  output logic              fetch_req,
  output logic [7:0]        disp_char,
  output logic [7:0]        disp_attr,
  output logic [3:0]        disp_pix
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   fill;
  logic [FIFO_AW:0]   free_space;
  logic [FIFO_AW:0]   burst_len;
  logic [1:0]         pix_idx;
  logic               rd_ok;
  logic               pop;
  mem_word_u          head;

  assign free_space = (FIFO_AW+1)'(FIFO_DEPTH) - fill;
  assign burst_len  = text_mode ? (FIFO_AW+1)'(BURST_TXT) : (FIFO_AW+1)'(BURST_GFX);
  assign fetch_req  = (free_space >= burst_len);

  assign head  = mem[rd_ptr];
  assign rd_ok = crt_rd && (fill != '0);
  // Graphics word leaves after its fourth pixel
  assign pop   = rd_ok && (text_mode || (pix_idx == 2'd3));

  always_ff @(posedge t_mem_clk) begin
    if (crt_ff_write) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (crt_ff_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({crt_ff_write, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Read side decode of the head word
  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      pix_idx   <= 2'd0;
      disp_char <= 8'd0;
      disp_attr <= 8'd0;
      disp_pix  <= 4'd0;
    end else if (text_mode) begin
      pix_idx <= 2'd0;
      if (rd_ok) begin
        disp_char <= head.txt.char_code;
        disp_attr <= head.txt.attr;
      end
    end else if (rd_ok) begin
      disp_pix <= head.gfx.pix[pix_idx];
      pix_idx  <= pix_idx + 2'd1;
    end
  end

endmodule

// File: design/mem_access_mux.sv
`timescale 1ns/100ps

module mem_access_mux
  import mem_seq_pkg::*;
(
  input  logic              t_mem_clk,
  input  logic              h_reset_n,
  input  logic              crt_busy,
  input  logic [ADDR_W-1:0] crt_addr,
  input  logic              cpu_rd_req,
  input  logic              cpu_wr_req,
  input  logic [ADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0] cpu_wdata,
  input  logic              t_data_ready_n,
  input  logic [DATA_W-1:0] t_mem_rdata,
  output logic              m_t_svga_req,
  output logic              m_mrd_mwr_n,
  output logic [ADDR_W-1:0] m_t_addr,
  output logic [DATA_W-1:0] m_t_wdata,
  output logic [DATA_W-1:0] mem_rdata_q,
  output logic [DATA_W-1:0] cpu_rdata,
  output logic              cpu_ack
);

  logic cpu_act;
  logic cpu_is_wr;
  logic cpu_start;
  logic mem_strobe;

  assign mem_strobe = !t_data_ready_n;
  // Held request is not restarted in its ack cycle
  assign cpu_start  = !crt_busy && !cpu_act && !cpu_ack && (cpu_rd_req || cpu_wr_req);

  always_ff @(posedge t_mem_clk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      cpu_act   <= 1'b0;
      cpu_is_wr <= 1'b0;
      cpu_ack   <= 1'b0;
    end else begin
      cpu_ack <= cpu_act && mem_strobe;
      if (cpu_start) begin
        cpu_act   <= 1'b1;
        cpu_is_wr <= cpu_wr_req;
      end else if (cpu_act && mem_strobe) begin
        cpu_act <= 1'b0;
      end
    end
  end

  // A started CPU access keeps the port until its strobe
  assign m_t_svga_req = crt_busy || cpu_act;
  assign m_mrd_mwr_n  = !(cpu_act && cpu_is_wr);
  assign m_t_addr     = cpu_act ? cpu_addr : crt_addr;
  assign m_t_wdata    = cpu_wdata;

  always_ff @(posedge t_mem_clk) begin
    if (mem_strobe) begin
      mem_rdata_q <= t_mem_rdata;
    end
    if (mem_strobe && cpu_act && !cpu_is_wr) begin
      cpu_rdata <= t_mem_rdata;
    end
  end

endmodule

// File: design/mem_seq_top.sv
`timescale 1ns/100ps

module mem_seq_top
  import mem_seq_pkg::*;
(
  input  logic              t_mem_clk,
  input  logic              h_reset_n,
  input  logic              text_mode,
  input  logic              sync_c_crt_line_end,
  input  logic              frame_start,
  input  logic              cpu_rd_req,
  input  logic              cpu_wr_req,
  input  logic [ADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0] cpu_wdata,
  output logic [DATA_W-1:0] cpu_rdata,
  output logic              cpu_ack,
  output logic              m_t_svga_req,
  output logic              m_mrd_mwr_n,
  output logic [ADDR_W-1:0] m_t_addr,
  output logic [DATA_W-1:0] m_t_wdata,
  input  logic              t_data_ready_n,
  input  logic [DATA_W-1:0] t_mem_rdata,
  input  logic              crt_rd,
  output logic [7:0]        disp_char,
  output logic [7:0]        disp_attr,
  output logic [3:0]        disp_pix,
  output logic              data_complete
);

  logic              fetch_req;
  logic              crt_busy;
  logic              crt_ff_write;
  logic [ADDR_W-1:0] crt_addr;
  logic [DATA_W-1:0] mem_rdata_q;

  crt_fetch_ctrl u_fetch_ctrl (
    .t_mem_clk           (t_mem_clk),
    .h_reset_n           (h_reset_n),
    .fetch_req           (fetch_req),
    .t_data_ready_n      (t_data_ready_n),
    .sync_c_crt_line_end (sync_c_crt_line_end),
    .text_mode           (text_mode),
    .crt_busy            (crt_busy),
    .crt_ff_write        (crt_ff_write),
    .data_complete       (data_complete)
  );

  crt_addr_gen u_addr_gen (
    .t_mem_clk           (t_mem_clk),
    .h_reset_n           (h_reset_n),
    .crt_ff_write        (crt_ff_write),
    .sync_c_crt_line_end (sync_c_crt_line_end),
    .frame_start         (frame_start),
    .crt_addr            (crt_addr)
  );

  crt_data_fifo u_data_fifo (
    .t_mem_clk    (t_mem_clk),
    .h_reset_n    (h_reset_n),
    .text_mode    (text_mode),
    .crt_ff_write (crt_ff_write),
    .wdata        (mem_rdata_q),
    .crt_rd       (crt_rd),
    .fetch_req    (fetch_req),
    .disp_char    (disp_char),
    .disp_attr    (disp_attr),
    .disp_pix     (disp_pix)
  );

  mem_access_mux u_access_mux (
    .t_mem_clk      (t_mem_clk),
    .h_reset_n      (h_reset_n),
    .crt_busy       (crt_busy),
    .crt_addr       (crt_addr),
    .cpu_rd_req     (cpu_rd_req),
    .cpu_wr_req     (cpu_wr_req),
    .cpu_addr       (cpu_addr),
    .cpu_wdata      (cpu_wdata),
    .t_data_ready_n (t_data_ready_n),
    .t_mem_rdata    (t_mem_rdata),
    .m_t_svga_req   (m_t_svga_req),
    .m_mrd_mwr_n    (m_mrd_mwr_n),
    .m_t_addr       (m_t_addr),
    .m_t_wdata      (m_t_wdata),
    .mem_rdata_q    (mem_rdata_q),
    .cpu_rdata      (cpu_rdata),
    .cpu_ack        (cpu_ack)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic t_mem_clk,
  output logic h_reset_n
);

  initial begin
    t_mem_clk = 1'b0;
    forever #4 t_mem_clk = ~t_mem_clk;
  end

  // Reset held over three rising edges
  initial begin
    h_reset_n = 1'b0;
    repeat (3) @(posedge t_mem_clk);
    h_reset_n <= 1'b1;
  end

endmodule

// File: verif/mem_seq_props.sv
`timescale 1ns/100ps

module mem_seq_props (
  input logic t_mem_clk,
  input logic h_reset_n,
  input logic t_data_ready_n,
  input logic crt_ff_write,
  input logic data_complete
);

  int fail_cnt = 0;

  // Write and done are separate FSM states
  a_wr_done_excl: assert property (@(posedge t_mem_clk) disable iff (!h_reset_n)
    !(crt_ff_write && data_complete))
    else begin
      fail_cnt++;
      $error("crt_ff_write and data_complete high in the same cycle");
    end

  a_done_one_cycle: assert property (@(posedge t_mem_clk) disable iff (!h_reset_n)
    data_complete |=> !data_complete)
    else begin
      fail_cnt++;
      $error("data_complete held for more than one cycle");
    end

  // Each FIFO write answers the strobe of the cycle before
  a_wr_after_strobe: assert property (@(posedge t_mem_clk) disable iff (!h_reset_n)
    crt_ff_write |-> $past(!t_data_ready_n))
    else begin
      fail_cnt++;
      $error("crt_ff_write without a memory strobe before it");
    end

endmodule

// File: verif/mem_seq_tb.sv
`timescale 1ns/100ps

module mem_seq_tb
  import mem_seq_pkg::*;
();

  // Words fetched plus words read, and worst cycles spent on each
  localparam int WORDS        = 200;
  localparam int CYC_PER_WORD = 12;
  localparam int WATCHDOG_NS  = WORDS * CYC_PER_WORD * 8;

  logic              t_mem_clk;
  logic              h_reset_n;
  logic              text_mode;
  logic              sync_c_crt_line_end;
  logic              frame_start;
  logic              cpu_rd_req;
  logic              cpu_wr_req;
  logic [ADDR_W-1:0] cpu_addr;
  logic [DATA_W-1:0] cpu_wdata;
  logic [DATA_W-1:0] cpu_rdata;
  logic              cpu_ack;
  logic              m_t_svga_req;
  logic              m_mrd_mwr_n;
  logic [ADDR_W-1:0] m_t_addr;
  logic [DATA_W-1:0] m_t_wdata;
  logic              t_data_ready_n;
  logic [DATA_W-1:0] t_mem_rdata;
  logic              crt_rd;
  logic [7:0]        disp_char;
  logic [7:0]        disp_attr;
  logic [3:0]        disp_pix;
  logic              data_complete;

  int                errors;
  int                rd_idx;
  int                burst_words;
  int                gap;
  int                cpu_mem_cnt;
  logic              strobe_now;
  logic              saw_wr_low;
  logic              saw_rd_low;
  logic [31:0]       lcg_state;
  logic [ADDR_W-1:0] strobe_addr;
  logic [ADDR_W-1:0] wr_addr_q [$];
  int                burst_len_q [$];
  logic [ADDR_W-1:0] cpu_mem_addr [4];
  logic [DATA_W-1:0] cpu_mem_data [4];

  tb_clk_gen u_clk_gen (
    .t_mem_clk (t_mem_clk),
    .h_reset_n (h_reset_n)
  );

  mem_seq_top u_dut (.*);

  bind crt_fetch_ctrl mem_seq_props u_props (
    .t_mem_clk      (t_mem_clk),
    .h_reset_n      (h_reset_n),
    .t_data_ready_n (t_data_ready_n),
    .crt_ff_write   (crt_ff_write),
    .data_complete  (data_complete)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Unwritten words read back as address XOR 5a5a
  function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] d;
    d = a ^ 16'h5a5a;
    for (int i = 0; i < 4; i++) begin
      if (i < cpu_mem_cnt && cpu_mem_addr[i] == a) begin
        d = cpu_mem_data[i];
      end
    end
    return d;
  endfunction

  // Memory model, 1 to 4 quiet cycles after each FIFO write
  initial begin
    t_data_ready_n = 1'b1;
    t_mem_rdata    = '0;
    lcg_state      = 32'h672bc672;
    gap            = 0;
    cpu_mem_cnt    = 0;
    forever begin
      @(negedge t_mem_clk);
      strobe_now = 1'b0;
      if (!t_data_ready_n) begin
        if (!m_mrd_mwr_n) begin
          cpu_mem_addr[cpu_mem_cnt % 4] = m_t_addr;
          cpu_mem_data[cpu_mem_cnt % 4] = m_t_wdata;
          cpu_mem_cnt++;
        end
        lcg_state = lcg_next(lcg_state);
        gap = 1 + int'(lcg_state[17:16]);
      end else if (h_reset_n && m_t_svga_req && !data_complete) begin
        if (gap > 0) begin
          gap--;
        end else begin
          strobe_now = 1'b1;
        end
      end
      strobe_addr = m_t_addr;
      @(posedge t_mem_clk);
      t_data_ready_n <= !strobe_now;
      t_mem_rdata    <= mem_read(strobe_addr);
    end
  end

  // Records every FIFO write address and the length of each burst
  initial begin
    burst_words = 0;
    saw_wr_low  = 1'b0;
    saw_rd_low  = 1'b0;
    forever begin
      @(negedge t_mem_clk);
      if (h_reset_n && u_dut.crt_ff_write) begin
        wr_addr_q.push_back(m_t_addr);
        burst_words++;
      end
      if (h_reset_n && data_complete) begin
        burst_len_q.push_back(burst_words);
        burst_words = 0;
      end
      if (cpu_wr_req && !m_mrd_mwr_n) saw_wr_low = 1'b1;
      if (cpu_rd_req && !m_mrd_mwr_n) saw_rd_low = 1'b1;
    end
  end

  task automatic pulse_rd();
    @(posedge t_mem_clk);
    crt_rd <= 1'b1;
    @(posedge t_mem_clk);
    crt_rd <= 1'b0;
    @(negedge t_mem_clk);
  endtask

  task automatic wait_word();
    int n;
    n = 0;
    while (wr_addr_q.size() <= rd_idx && n < 200) begin
      @(posedge t_mem_clk);
      n++;
    end
    if (wr_addr_q.size() <= rd_idx) begin
      errors++;
      $display("No FIFO word arrived for read %0d", rd_idx);
    end
  endtask

  task automatic read_text_word();
    mem_word_u exp;
    wait_word();
    exp = wr_addr_q[rd_idx] ^ 16'h5a5a;
    pulse_rd();
    if (disp_char !== exp.txt.char_code) begin
      errors++;
      $display("error disp_char %h expected %h", disp_char, exp.txt.char_code);
    end
    if (disp_attr !== exp.txt.attr) begin
      errors++;
      $display("error disp_attr %h expected %h", disp_attr, exp.txt.attr);
    end
    rd_idx++;
  endtask

  task automatic read_gfx_word();
    mem_word_u exp;
    wait_word();
    exp = wr_addr_q[rd_idx] ^ 16'h5a5a;
    for (int j = 0; j < 4; j++) begin
      pulse_rd();
      if (disp_pix !== exp.gfx.pix[j]) begin
        errors++;
        $display("error disp_pix %h expected %h", disp_pix, exp.gfx.pix[j]);
      end
    end
    rd_idx++;
  endtask

  task automatic wait_fetch_idle();
    int n;
    n = 0;
    while ((u_dut.crt_busy || u_dut.fetch_req) && n < 1000) begin
      @(negedge t_mem_clk);
      n++;
    end
    if (u_dut.crt_busy || u_dut.fetch_req) begin
      errors++;
      $display("Fetches did not stop with a nearly full FIFO");
    end
  endtask

  task automatic cpu_access(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d);
    int n;
    n = 0;
    @(posedge t_mem_clk);
    cpu_wr_req <= wr;
    cpu_rd_req <= !wr;
    cpu_addr   <= a;
    cpu_wdata  <= d;
    do begin
      @(negedge t_mem_clk);
      n++;
    end while (!cpu_ack && n < 50);
    if (!cpu_ack) begin
      errors++;
      $display("No cpu_ack for the CPU access to %h", a);
    end
    @(posedge t_mem_clk);
    cpu_wr_req <= 1'b0;
    cpu_rd_req <= 1'b0;
  endtask

  // Runs before the first word lands in the FIFO
  task automatic check_empty_read();
    logic [7:0] c0;
    logic [7:0] a0;
    logic [3:0] p0;
    c0 = disp_char;
    a0 = disp_attr;
    p0 = disp_pix;
    pulse_rd();
    if (disp_char !== c0 || disp_attr !== a0 || disp_pix !== p0) begin
      errors++;
      $display("error disp_char/attr/pix %h %h %h expected %h %h %h",
               disp_char, disp_attr, disp_pix, c0, a0, p0);
    end
  endtask

  task automatic test_text_burst();
    int n;
    n = 0;
    while (burst_len_q.size() == 0 && n < 500) begin
      @(posedge t_mem_clk);
      n++;
    end
    if (burst_len_q.size() == 0) begin
      errors++;
      $display("No data_complete after the first text burst");
    end else begin
      if (burst_len_q[0] != BURST_TXT) begin
        errors++;
        $display("error burst_words %h expected %h", burst_len_q[0], BURST_TXT);
      end
      for (int i = 0; i < BURST_TXT; i++) begin
        if (wr_addr_q[i] !== ADDR_W'(i)) begin
          errors++;
          $display("error m_t_addr %h expected %h", wr_addr_q[i], i);
        end
      end
    end
    repeat (BURST_TXT) read_text_word();
  endtask

  task automatic test_fifo_limit();
    int n_wr;
    wait_fetch_idle();
    n_wr = wr_addr_q.size();
    repeat (40) @(negedge t_mem_clk);
    if (wr_addr_q.size() != n_wr || m_t_svga_req) begin
      errors++;
      $display("A fetch ran without room for a burst");
    end
    if (FIFO_DEPTH - (n_wr - rd_idx) >= BURST_TXT) begin
      errors++;
      $display("Fetches stopped with room left for a burst");
    end
  endtask

  task automatic test_cpu_access();
    cpu_access(1'b1, 16'h1234, 16'hbeef);
    if (!saw_wr_low) begin
      errors++;
      $display("m_mrd_mwr_n never went low during the CPU write");
    end
    cpu_access(1'b0, 16'h1234, 16'h0000);
    @(negedge t_mem_clk);
    if (cpu_rdata !== 16'hbeef) begin
      errors++;
      $display("error cpu_rdata %h expected %h", cpu_rdata, 16'hbeef);
    end
    if (saw_rd_low) begin
      errors++;
      $display("m_mrd_mwr_n went low during the CPU read");
    end
  endtask

  task automatic test_gfx_decode();
    int nb;
    int n;
    @(posedge t_mem_clk);
    text_mode <= 1'b0;
    nb = burst_len_q.size();
    n  = 0;
    while (burst_len_q.size() == nb && n < 40) begin
      read_gfx_word();
      n++;
    end
    if (burst_len_q.size() == nb) begin
      errors++;
      $display("No graphics burst completed");
    end else if (burst_len_q[nb] != BURST_GFX) begin
      errors++;
      $display("error burst_words %h expected %h", burst_len_q[nb], BURST_GFX);
    end
    // Still in the first row, so each address equals its write count
    for (int i = 0; i < wr_addr_q.size(); i++) begin
      if (wr_addr_q[i] !== ADDR_W'(i)) begin
        errors++;
        $display("error m_t_addr %h expected %h", wr_addr_q[i], ADDR_W'(i));
      end
    end
  endtask

  task automatic test_line_end();
    int nb;
    int idx;
    int n;
    n = 0;
    // Drain until the FIFO asks for the next burst
    while (!u_dut.fetch_req && n < 40) begin
      read_gfx_word();
      n++;
    end
    while (burst_words < 3 && n < 200) begin
      @(posedge t_mem_clk);
      n++;
    end
    nb  = burst_len_q.size();
    idx = wr_addr_q.size();
    sync_c_crt_line_end <= 1'b1;
    @(posedge t_mem_clk);
    sync_c_crt_line_end <= 1'b0;
    n = 0;
    while (wr_addr_q.size() == idx && n < 40) begin
      read_gfx_word();
      n++;
    end
    if (burst_len_q.size() <= nb || burst_len_q[nb] != 3) begin
      errors++;
      $display("Line end did not cut the burst after three words");
    end
    if (wr_addr_q.size() == idx) begin
      errors++;
      $display("No fetch followed the line end");
    end else if (wr_addr_q[idx] !== ADDR_W'(ROW_PITCH)) begin
      errors++;
      $display("error m_t_addr %h expected %h", wr_addr_q[idx], ROW_PITCH);
    end
    wait_fetch_idle();
    @(posedge t_mem_clk);
    frame_start <= 1'b1;
    @(posedge t_mem_clk);
    frame_start <= 1'b0;
    idx = wr_addr_q.size();
    n   = 0;
    while (wr_addr_q.size() == idx && n < 40) begin
      read_gfx_word();
      n++;
    end
    if (wr_addr_q.size() == idx || wr_addr_q[idx] !== '0) begin
      errors++;
      $display("Fetch after frame_start did not start at address 0");
    end
  endtask

  initial begin
    errors              = 0;
    rd_idx              = 0;
    text_mode           = 1'b1;
    sync_c_crt_line_end = 1'b0;
    frame_start         = 1'b0;
    cpu_rd_req          = 1'b0;
    cpu_wr_req          = 1'b0;
    cpu_addr            = '0;
    cpu_wdata           = '0;
    crt_rd              = 1'b0;
    wait (h_reset_n);
    check_empty_read();
    test_text_burst();
    test_fifo_limit();
    test_cpu_access();
    test_gfx_decode();
    test_line_end();
    repeat (2) @(negedge t_mem_clk);
    $display("Checks done: %0d errors, %0d assertion failures",
             errors, u_dut.u_fetch_ctrl.u_props.fail_cnt);
    if (errors == 0 && u_dut.u_fetch_ctrl.u_props.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: flist.f
design/mem_seq_pkg.sv
design/crt_fetch_ctrl.sv
design/crt_addr_gen.sv
design/crt_data_fifo.sv
design/mem_access_mux.sv
design/mem_seq_top.sv
verif/tb_clk_gen.sv
verif/mem_seq_props.sv
verif/mem_seq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_seq_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
